//--- rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;
    localparam int IMEM_AW = $clog2(IMEM_WORDS);
    localparam int DMEM_AW = $clog2(DMEM_WORDS);
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    // major opcodes, inst[6:0].
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [3:0] {
        br_none,
        br_eq,
        br_ne,
        br_lt,
        br_ge,
        br_ltu,
        br_geu,
        br_jal,
        br_jalr
    } branch_e;

    // mem_none must stay at zero, a cleared ctrl_t means no access.
    typedef enum logic [2:0] {
        mem_none,
        mem_lw,
        mem_lb,
        mem_lbu,
        mem_sw,
        mem_sb
    } mem_e;

    typedef struct packed {
        alu_op_e alu_op;
        branch_e branch;
        mem_e    mem;
        logic    reg_we;
        logic    src1_is_pc;
        logic    src2_is_imm;
        logic    link;
        logic    halt;
        logic    illegal;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [4:0]  rd;
        logic        we;
        logic [31:0] wdata;
    } commit_t;

endpackage

`default_nettype wire

//--- rtl/rv_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module rv_fetch (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      run,
    input  logic                      stop,
    input  logic                      stop_illegal,
    input  logic [31:0]               next_pc,
    input  logic                      load_en,
    input  logic [rv_pkg::IMEM_AW-1:0] load_addr,
    input  logic [31:0]               load_data,
    output logic [31:0]               pc,
    output logic [31:0]               inst,
    output logic                      halted,
    output logic                      illegal_stop
);

    logic [31:0] imem [rv_pkg::IMEM_WORDS];
    logic        advance;

    assign advance = run && !halted;

    // program load only while the core is parked.
    always_ff @(posedge clk) begin
        if (load_en && !run) begin
            imem[load_addr] <= load_data;
        end
    end

    assign inst = imem[pc[rv_pkg::IMEM_AW+1:2]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc           <= rv_pkg::RESET_PC;
            halted       <= 1'b0;
            illegal_stop <= 1'b0;
        end else if (advance) begin
            if (stop) begin
                halted       <= 1'b1;
                illegal_stop <= stop_illegal;
            end else begin
                pc <= next_pc;
            end
        end
    end

    pc_aligned_a: assert property (@(posedge clk) disable iff (!rst_n)
        advance |-> (pc[1:0] == 2'b00));

endmodule

`default_nettype wire

//--- rtl/rv_decode.sv
`timescale 1ns/100ps
`default_nettype none

module rv_decode (
    input  logic [31:0]   inst,
    output logic [4:0]    rs1,
    output logic [4:0]    rs2,
    output logic [4:0]    rd,
    output logic [31:0]   imm,
    output rv_pkg::ctrl_t ctrl
);

    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        logic bad;
        bad  = 1'b0;
        imm  = imm_i;
        ctrl = '0;
        ctrl.alu_op = rv_pkg::alu_add;
        case (rv_pkg::opcode_e'(inst[6:0]))
            rv_pkg::op_lui: begin
                imm = imm_u;
                ctrl.alu_op      = rv_pkg::alu_pass_b;
                ctrl.src2_is_imm = 1'b1;
                ctrl.reg_we      = 1'b1;
            end
            rv_pkg::op_auipc: begin
                imm = imm_u;
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_imm = 1'b1;
                ctrl.reg_we      = 1'b1;
            end
            rv_pkg::op_jal: begin
                imm = imm_j;
                ctrl.branch = rv_pkg::br_jal;
                ctrl.link   = 1'b1;
                ctrl.reg_we = 1'b1;
            end
            rv_pkg::op_jalr: begin
                ctrl.branch      = rv_pkg::br_jalr;
                ctrl.src2_is_imm = 1'b1;
                ctrl.link        = 1'b1;
                ctrl.reg_we      = 1'b1;
                bad = (funct3 != 3'b000);
            end
            rv_pkg::op_branch: begin
                imm = imm_b;
                case (funct3)
                    3'b000:  ctrl.branch = rv_pkg::br_eq;
                    3'b001:  ctrl.branch = rv_pkg::br_ne;
                    3'b100:  ctrl.branch = rv_pkg::br_lt;
                    3'b101:  ctrl.branch = rv_pkg::br_ge;
                    3'b110:  ctrl.branch = rv_pkg::br_ltu;
                    3'b111:  ctrl.branch = rv_pkg::br_geu;
                    default: bad = 1'b1;
                endcase
            end
            rv_pkg::op_load: begin
                ctrl.src2_is_imm = 1'b1;
                ctrl.reg_we      = 1'b1;
                case (funct3)
                    3'b000:  ctrl.mem = rv_pkg::mem_lb;
                    3'b010:  ctrl.mem = rv_pkg::mem_lw;
                    3'b100:  ctrl.mem = rv_pkg::mem_lbu;
                    default: bad = 1'b1;
                endcase
            end
            rv_pkg::op_store: begin
                imm = imm_s;
                ctrl.src2_is_imm = 1'b1;
                case (funct3)
                    3'b000:  ctrl.mem = rv_pkg::mem_sb;
                    3'b010:  ctrl.mem = rv_pkg::mem_sw;
                    default: bad = 1'b1;
                endcase
            end
            rv_pkg::op_imm, rv_pkg::op_reg: begin
                ctrl.src2_is_imm = (inst[5] == 1'b0);
                ctrl.reg_we      = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = (inst[5] && funct7[5]) ? rv_pkg::alu_sub
                                                                 : rv_pkg::alu_add;
                    3'b001:  ctrl.alu_op = rv_pkg::alu_sll;
                    3'b010:  ctrl.alu_op = rv_pkg::alu_slt;
                    3'b011:  ctrl.alu_op = rv_pkg::alu_sltu;
                    3'b100:  ctrl.alu_op = rv_pkg::alu_xor;
                    3'b101:  ctrl.alu_op = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                    3'b110:  ctrl.alu_op = rv_pkg::alu_or;
                    default: ctrl.alu_op = rv_pkg::alu_and;
                endcase
                // funct7 only qualifies shifts, and every register op.
                if (inst[5] || funct3 == 3'b001 || funct3 == 3'b101) begin
                    if (funct7 == 7'b0100000) begin
                        bad = !(funct3 == 3'b101 || (inst[5] && funct3 == 3'b000));
                    end else begin
                        bad = (funct7 != 7'b0000000);
                    end
                end
            end
            rv_pkg::op_system: begin
                ctrl.halt = 1'b1;
                bad = (inst != 32'h0010_0073);
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            ctrl.illegal = 1'b1;
            ctrl.halt    = 1'b1;
            ctrl.reg_we  = 1'b0;
            ctrl.mem     = rv_pkg::mem_none;
        end
    end

endmodule

`default_nettype wire

//--- rtl/rv_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module rv_regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] src1,
    output logic [31:0] src2
);

    // x0 has no storage.
    logic [31:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign src1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign src2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- rtl/rv_execute.sv
`timescale 1ns/100ps
`default_nettype none

module rv_execute (
    input  rv_pkg::ctrl_t ctrl,
    input  logic [31:0]   pc,
    input  logic [31:0]   src1,
    input  logic [31:0]   src2,
    input  logic [31:0]   imm,
    output logic [31:0]   alu_result,
    output logic [31:0]   next_pc
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [4:0]  shamt;
    logic        eq;
    logic        lt;
    logic        ltu;
    logic        taken;
    logic [31:0] pc_plus4;
    logic [31:0] pc_target;
    logic [31:0] jalr_sum;

    assign op_a  = ctrl.src1_is_pc ? pc : src1;
    assign op_b  = ctrl.src2_is_imm ? imm : src2;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            rv_pkg::alu_add:    alu_result = op_a + op_b;
            rv_pkg::alu_sub:    alu_result = op_a - op_b;
            rv_pkg::alu_and:    alu_result = op_a & op_b;
            rv_pkg::alu_or:     alu_result = op_a | op_b;
            rv_pkg::alu_xor:    alu_result = op_a ^ op_b;
            rv_pkg::alu_slt:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::alu_sltu:   alu_result = {31'b0, op_a < op_b};
            rv_pkg::alu_sll:    alu_result = op_a << shamt;
            rv_pkg::alu_srl:    alu_result = op_a >> shamt;
            rv_pkg::alu_sra:    alu_result = $unsigned($signed(op_a) >>> shamt);
            rv_pkg::alu_pass_b: alu_result = op_b;
            default:            alu_result = op_a + op_b;
        endcase
    end

    // branch compare always uses the register operands.
    assign eq  = (src1 == src2);
    assign lt  = ($signed(src1) < $signed(src2));
    assign ltu = (src1 < src2);

    always_comb begin
        case (ctrl.branch)
            rv_pkg::br_eq:  taken = eq;
            rv_pkg::br_ne:  taken = !eq;
            rv_pkg::br_lt:  taken = lt;
            rv_pkg::br_ge:  taken = !lt;
            rv_pkg::br_ltu: taken = ltu;
            rv_pkg::br_geu: taken = !ltu;
            rv_pkg::br_jal: taken = 1'b1;
            default:        taken = 1'b0;
        endcase
    end

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + imm;
    assign jalr_sum  = src1 + imm;

    always_comb begin
        if (ctrl.branch == rv_pkg::br_jalr) begin
            next_pc = {jalr_sum[31:1], 1'b0};
        end else if (taken) begin
            next_pc = pc_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

endmodule

`default_nettype wire

//--- rtl/rv_lsu.sv
`timescale 1ns/100ps
`default_nettype none

module rv_lsu (
    input  logic          clk,
    input  logic          rst_n,
    input  rv_pkg::ctrl_t ctrl,
    input  logic [31:0]   alu_result,
    input  logic [31:0]   store_data,
    input  logic [31:0]   pc,
    output logic [31:0]   wb_data
);

    logic [31:0]               dmem [rv_pkg::DMEM_WORDS];
    logic [rv_pkg::DMEM_AW-1:0] word_idx;
    logic [1:0]                byte_off;
    logic [31:0]               rd_word;
    logic [7:0]                rd_byte;

    // address wraps modulo the array depth.
    assign word_idx = alu_result[rv_pkg::DMEM_AW+1:2];
    assign byte_off = alu_result[1:0];
    assign rd_word  = dmem[word_idx];
    assign rd_byte  = rd_word[{byte_off, 3'b000} +: 8];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_pkg::DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ctrl.mem == rv_pkg::mem_sw) begin
            dmem[word_idx] <= store_data;
        end else if (ctrl.mem == rv_pkg::mem_sb) begin
            dmem[word_idx][{byte_off, 3'b000} +: 8] <= store_data[7:0];
        end
    end

    always_comb begin
        if (ctrl.link) begin
            wb_data = pc + 32'd4;
        end else begin
            case (ctrl.mem)
                rv_pkg::mem_lw:  wb_data = rd_word;
                rv_pkg::mem_lb:  wb_data = {{24{rd_byte[7]}}, rd_byte};
                rv_pkg::mem_lbu: wb_data = {24'b0, rd_byte};
                default:         wb_data = alu_result;
            endcase
        end
    end

    word_aligned_a: assert property (@(posedge clk) disable iff (!rst_n)
        (ctrl.mem == rv_pkg::mem_lw || ctrl.mem == rv_pkg::mem_sw)
            |-> (alu_result[1:0] == 2'b00));

endmodule

`default_nettype wire

//--- rtl/rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      run,
    input  logic                      load_en,
    input  logic [rv_pkg::IMEM_AW-1:0] load_addr,
    input  logic [31:0]               load_data,
    output rv_pkg::commit_t           commit,
    output logic                      commit_valid,
    output logic                      halted,
    output logic                      illegal_stop
);

    logic [31:0]   pc;
    logic [31:0]   inst;
    logic [4:0]    rs1;
    logic [4:0]    rs2;
    logic [4:0]    rd;
    logic [31:0]   imm;
    rv_pkg::ctrl_t ctrl;
    rv_pkg::ctrl_t lsu_ctrl;
    logic [31:0]   src1;
    logic [31:0]   src2;
    logic [31:0]   alu_result;
    logic [31:0]   next_pc;
    logic [31:0]   wb_data;

    assign commit_valid = run && !halted;

    // no store lands unless the instruction retires.
    assign lsu_ctrl = commit_valid ? ctrl : '0;

    rv_fetch u_fetch (
        .clk(clk), .rst_n(rst_n), .run(run),
        .stop(ctrl.halt), .stop_illegal(ctrl.illegal), .next_pc(next_pc),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .pc(pc), .inst(inst), .halted(halted), .illegal_stop(illegal_stop)
    );

    rv_decode u_decode (
        .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .ctrl(ctrl)
    );

    rv_regfile u_regfile (
        .clk(clk), .rst_n(rst_n), .rs1(rs1), .rs2(rs2), .rd(rd),
        .we(ctrl.reg_we && commit_valid), .wdata(wb_data),
        .src1(src1), .src2(src2)
    );

    rv_execute u_execute (
        .ctrl(ctrl), .pc(pc), .src1(src1), .src2(src2), .imm(imm),
        .alu_result(alu_result), .next_pc(next_pc)
    );

    rv_lsu u_lsu (
        .clk(clk), .rst_n(rst_n), .ctrl(lsu_ctrl), .alu_result(alu_result),
        .store_data(src2), .pc(pc), .wb_data(wb_data)
    );

    assign commit = '{pc: pc, inst: inst, rd: rd, we: ctrl.reg_we, wdata: wb_data};

endmodule

`default_nettype wire

//--- testbench/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam int NUM_TESTS   = 5;
localparam int MAX_WORDS   = 24;
localparam int MAX_COMMITS = 20;

localparam logic [6:0] OPC_LUI   = 7'b0110111;
localparam logic [6:0] OPC_AUIPC = 7'b0010111;
localparam logic [6:0] OPC_JALR  = 7'b1100111;
localparam logic [6:0] OPC_LOAD  = 7'b0000011;
localparam logic [6:0] OPC_IMM   = 7'b0010011;
localparam logic [31:0] EBREAK   = 32'h0010_0073;

string       test_name [NUM_TESTS];
logic [31:0] prog_word [NUM_TESTS][MAX_WORDS];
int          prog_len  [NUM_TESTS];
logic [31:0] exp_pc    [NUM_TESTS][MAX_COMMITS];
logic [4:0]  exp_rd    [NUM_TESTS][MAX_COMMITS];
logic        exp_we    [NUM_TESTS][MAX_COMMITS];
logic [31:0] exp_wdata [NUM_TESTS][MAX_COMMITS];
int          exp_len   [NUM_TESTS];
logic        exp_illegal [NUM_TESTS];

// word that never retires, such as a skipped branch shadow.
task automatic add_word(input int t, input logic [31:0] w);
    prog_word[t][prog_len[t]] = w;
    prog_len[t]++;
endtask

// word that retires at its own address.
task automatic step(input int t, input logic [31:0] w, input logic [4:0] rd,
                    input logic we, input logic [31:0] wdata);
    add_word(t, w);
    exp_pc[t][exp_len[t]]    = 32'((prog_len[t] - 1) * 4);
    exp_rd[t][exp_len[t]]    = rd;
    exp_we[t][exp_len[t]]    = we;
    exp_wdata[t][exp_len[t]] = wdata;
    exp_len[t]++;
endtask

task automatic build_tables(input logic [11:0] ia, input logic [11:0] ib);
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] v5;
    v1 = {{20{ia[11]}}, ia};
    v2 = {{20{ib[11]}}, ib};
    v5 = 32'hFFFF_FFF0;
    for (int t = 0; t < NUM_TESTS; t++) begin
        prog_len[t] = 0;
        exp_len[t] = 0;
        exp_illegal[t] = 1'b0;
    end

    test_name[0] = "alu";
    step(0, enc_i(ia, 5'd0, 3'd0, 5'd1, OPC_IMM), 5'd1, 1'b1, v1);
    step(0, enc_i(ib, 5'd0, 3'd0, 5'd2, OPC_IMM), 5'd2, 1'b1, v2);
    step(0, enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), 5'd3, 1'b1, v1 + v2);
    step(0, enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd4), 5'd4, 1'b1, v1 - v2);
    step(0, enc_i(12'hFF0, 5'd0, 3'd0, 5'd5, OPC_IMM), 5'd5, 1'b1, v5);
    step(0, enc_i(12'h402, 5'd5, 3'd5, 5'd6, OPC_IMM), 5'd6, 1'b1, 32'hFFFF_FFFC);
    step(0, enc_r(7'h00, 5'd2, 5'd5, 3'd5, 5'd7), 5'd7, 1'b1, v5 >> v2[4:0]);
    step(0, enc_r(7'h00, 5'd1, 5'd5, 3'd2, 5'd8), 5'd8, 1'b1,
         ($signed(v5) < $signed(v1)) ? 32'd1 : 32'd0);
    step(0, enc_r(7'h00, 5'd1, 5'd5, 3'd3, 5'd9), 5'd9, 1'b1,
         (v5 < v1) ? 32'd1 : 32'd0);
    step(0, enc_i(12'h555, 5'd1, 3'd4, 5'd10, OPC_IMM), 5'd10, 1'b1, v1 ^ 32'h555);
    step(0, enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd11), 5'd11, 1'b1, v1 & v2);
    step(0, enc_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd12), 5'd12, 1'b1, v1 | v2);
    // x0 write retires with its value, then x0 reads back as zero.
    step(0, enc_i(12'd5, 5'd1, 3'd0, 5'd0, OPC_IMM), 5'd0, 1'b1, v1 + 32'd5);
    step(0, enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd13), 5'd13, 1'b1, v1);
    step(0, enc_r(7'h00, 5'd2, 5'd1, 3'd1, 5'd14), 5'd14, 1'b1, v1 << v2[4:0]);
    step(0, EBREAK, 5'd0, 1'b0, 32'd0);

    test_name[1] = "upper_and_jumps";
    step(1, enc_u(20'h12345, 5'd1, OPC_LUI), 5'd1, 1'b1, 32'h1234_5000);
    step(1, enc_u(20'h00001, 5'd2, OPC_AUIPC), 5'd2, 1'b1, 32'h0000_1004);
    step(1, enc_j(21'd12, 5'd3), 5'd3, 1'b1, 32'd12);
    add_word(1, enc_i(12'd1, 5'd0, 3'd0, 5'd4, OPC_IMM));
    add_word(1, enc_i(12'd2, 5'd0, 3'd0, 5'd4, OPC_IMM));
    step(1, enc_i(12'd33, 5'd0, 3'd0, 5'd5, OPC_IMM), 5'd5, 1'b1, 32'd33);
    // target 33 lands on 32.
    step(1, enc_i(12'd0, 5'd5, 3'd0, 5'd6, OPC_JALR), 5'd6, 1'b1, 32'd28);
    add_word(1, enc_i(12'd3, 5'd0, 3'd0, 5'd4, OPC_IMM));
    step(1, EBREAK, 5'd0, 1'b0, 32'd0);

    test_name[2] = "branches";
    step(2, enc_i(12'hFFF, 5'd0, 3'd0, 5'd1, OPC_IMM), 5'd1, 1'b1, 32'hFFFF_FFFF);
    step(2, enc_i(12'd1, 5'd0, 3'd0, 5'd2, OPC_IMM), 5'd2, 1'b1, 32'd1);
    step(2, enc_b(13'd8, 5'd2, 5'd1, 3'd0), 5'd0, 1'b0, 32'd0);
    step(2, enc_b(13'd8, 5'd2, 5'd1, 3'd1), 5'd0, 1'b0, 32'd0);
    add_word(2, enc_i(12'd9, 5'd0, 3'd0, 5'd9, OPC_IMM));
    step(2, enc_b(13'd8, 5'd2, 5'd1, 3'd4), 5'd0, 1'b0, 32'd0);
    add_word(2, enc_i(12'd9, 5'd0, 3'd0, 5'd9, OPC_IMM));
    step(2, enc_b(13'd8, 5'd2, 5'd1, 3'd6), 5'd0, 1'b0, 32'd0);
    step(2, enc_b(13'd8, 5'd2, 5'd1, 3'd5), 5'd0, 1'b0, 32'd0);
    step(2, enc_b(13'd8, 5'd2, 5'd1, 3'd7), 5'd0, 1'b0, 32'd0);
    add_word(2, enc_i(12'd9, 5'd0, 3'd0, 5'd9, OPC_IMM));
    step(2, enc_b(13'd8, 5'd2, 5'd2, 3'd0), 5'd0, 1'b0, 32'd0);
    add_word(2, enc_i(12'd9, 5'd0, 3'd0, 5'd9, OPC_IMM));
    step(2, enc_b(13'd8, 5'd2, 5'd2, 3'd1), 5'd0, 1'b0, 32'd0);
    // operands swapped, so the order compares flip direction.
    step(2, enc_b(13'd8, 5'd1, 5'd2, 3'd4), 5'd0, 1'b0, 32'd0);
    step(2, enc_b(13'd8, 5'd1, 5'd2, 3'd6), 5'd0, 1'b0, 32'd0);
    add_word(2, enc_i(12'd9, 5'd0, 3'd0, 5'd9, OPC_IMM));
    step(2, enc_b(13'd8, 5'd1, 5'd2, 3'd5), 5'd0, 1'b0, 32'd0);
    add_word(2, enc_i(12'd9, 5'd0, 3'd0, 5'd9, OPC_IMM));
    step(2, enc_b(13'd8, 5'd1, 5'd2, 3'd7), 5'd0, 1'b0, 32'd0);
    step(2, EBREAK, 5'd0, 1'b0, 32'd0);

    test_name[3] = "loads_stores";
    step(3, enc_u(20'h89ABC, 5'd1, OPC_LUI), 5'd1, 1'b1, 32'h89AB_C000);
    step(3, enc_i(12'h7F0, 5'd1, 3'd0, 5'd1, OPC_IMM), 5'd1, 1'b1, 32'h89AB_C7F0);
    step(3, enc_s(12'd16, 5'd1, 5'd0, 3'd2), 5'd0, 1'b0, 32'd0);
    step(3, enc_i(12'd16, 5'd0, 3'd2, 5'd2, OPC_LOAD), 5'd2, 1'b1, 32'h89AB_C7F0);
    step(3, enc_i(12'h05A, 5'd0, 3'd0, 5'd3, OPC_IMM), 5'd3, 1'b1, 32'h0000_005A);
    step(3, enc_s(12'd17, 5'd3, 5'd0, 3'd0), 5'd0, 1'b0, 32'd0);
    step(3, enc_i(12'd16, 5'd0, 3'd2, 5'd4, OPC_LOAD), 5'd4, 1'b1, 32'h89AB_5AF0);
    step(3, enc_i(12'd19, 5'd0, 3'd0, 5'd5, OPC_LOAD), 5'd5, 1'b1, 32'hFFFF_FF89);
    step(3, enc_i(12'd19, 5'd0, 3'd4, 5'd6, OPC_LOAD), 5'd6, 1'b1, 32'h0000_0089);
    step(3, enc_i(12'd17, 5'd0, 3'd0, 5'd7, OPC_LOAD), 5'd7, 1'b1, 32'h0000_005A);
    step(3, EBREAK, 5'd0, 1'b0, 32'd0);

    test_name[4] = "illegal_stop";
    step(4, enc_i(12'd7, 5'd0, 3'd0, 5'd1, OPC_IMM), 5'd1, 1'b1, 32'd7);
    step(4, 32'h0000_0000, 5'd0, 1'b0, 32'd0);
    exp_illegal[4] = 1'b1;
endtask

`endif

//--- testbench/tb_rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;

    logic            clk;
    logic            rst_n;
    logic            run;
    logic            load_en;
    logic [7:0]      load_addr;
    logic [31:0]     load_data;
    rv_pkg::commit_t commit;
    logic            commit_valid;
    logic            halted;
    logic            illegal_stop;

    int errors;
    int passed;
    int failed;
    int seed;

    rv_core u_dut (
        .clk(clk), .rst_n(rst_n), .run(run),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
        .commit(commit), .commit_valid(commit_valid),
        .halted(halted), .illegal_stop(illegal_stop)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    `include "tb_programs.svh"

    task automatic check(input string what, input logic [31:0] got,
                         input logic [31:0] expected);
        if (got !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #0.5;
        rst_n = 1'b0;
        run = 1'b0;
        load_en = 1'b0;
        repeat (4) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        @(negedge clk);
        check("commit_valid after reset", {31'b0, commit_valid}, 32'd0);
        check("halted after reset", {31'b0, halted}, 32'd0);
        check("illegal_stop after reset", {31'b0, illegal_stop}, 32'd0);
    endtask

    task automatic load_program(input int t);
        for (int i = 0; i < prog_len[t]; i++) begin
            @(posedge clk);
            #0.5;
            load_en = 1'b1;
            load_addr = 8'(i);
            load_data = prog_word[t][i];
        end
        @(posedge clk);
        #0.5;
        load_en = 1'b0;
        run = 1'b1;
    endtask

    task automatic run_test(input int t);
        int start_errors;
        int idx;
        int cyc;
        logic stopped;
        start_errors = errors;
        idx = 0;
        cyc = 0;
        stopped = 1'b0;
        apply_reset();
        load_program(t);
        while (!stopped && cyc < 500) begin
            @(negedge clk);
            if (halted) begin
                stopped = 1'b1;
            end else begin
                if (commit_valid && idx >= exp_len[t]) begin
                    $display("Unexpected extra commit at pc %h in test %s",
                             commit.pc, test_name[t]);
                    errors++;
                end else if (commit_valid) begin
                    check("commit pc", commit.pc, exp_pc[t][idx]);
                    check("commit inst", commit.inst, prog_word[t][exp_pc[t][idx] >> 2]);
                    check("commit we", {31'b0, commit.we}, {31'b0, exp_we[t][idx]});
                    if (exp_we[t][idx]) begin
                        check("commit rd", {27'b0, commit.rd}, {27'b0, exp_rd[t][idx]});
                        check("commit wdata", commit.wdata, exp_wdata[t][idx]);
                    end
                    idx++;
                end
                @(posedge clk);
                cyc++;
            end
        end
        if (!stopped) begin
            $display("Timed out after 500 cycles waiting for halted in test %s", test_name[t]);
            errors++;
        end
        if (idx < exp_len[t]) begin
            $display("Only %0d of %0d commits seen in test %s", idx, exp_len[t], test_name[t]);
            errors++;
        end
        check("illegal_stop", {31'b0, illegal_stop}, {31'b0, exp_illegal[t]});
        // run stays high, the core must stay quiet.
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check("commit_valid after stop", {31'b0, commit_valid}, 32'd0);
        end
        @(posedge clk);
        #0.5;
        run = 1'b0;
        if (errors == start_errors) begin
            $display("test %s: pass", test_name[t]);
            passed++;
        end else begin
            $display("test %s: FAIL", test_name[t]);
            failed++;
        end
    endtask

    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        rst_n = 1'b0;
        run = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        errors = 0;
        passed = 0;
        failed = 0;
        seed = 32'hb929_82c4;
        r1 = $random(seed);
        r2 = $random(seed);
        // x1 stays non-negative so slt and sltu differ against x5.
        build_tables({1'b0, r1[10:0]}, r2[11:0]);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("tests passed: %0d, failed: %0d", passed, failed);
        if (failed == 0 && errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+testbench
rtl/rv_pkg.sv
rtl/rv_fetch.sv
rtl/rv_decode.sv
rtl/rv_regfile.sv
rtl/rv_execute.sv
rtl/rv_lsu.sv
rtl/rv_core.sv
testbench/tb_rv_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rv_core \
    -f sim.f -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_rv_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Test completed successfully$" sim.log; then
    exit 0
fi
exit 1
